// File: hw/zx_tape_params.svh
/* addresses, region limits and buffer size for the tape fast-load path
   include wherever a block needs the ROM entry points or the buffer width */
`ifndef ZX_TAPE_PARAMS_SVH
`define ZX_TAPE_PARAMS_SVH

// ====================
// tape buffer
// ====================
`define TAPE_ADDR_W 14 // 16k bytes of tape RAM

// ====================
// ROM load entry points
// ====================
// the loader starts on the entry fetch and stays armed
// while the CPU keeps fetching below the limit
`define ZX81_LOAD_ENTRY 16'h0347
`define ZX81_LOAD_END 16'h03C3

`define ZX80_LOAD_ENTRY 16'h0207
`define ZX80_LOAD_END 16'h024D

// ====================
// destination in system RAM
// ====================
`define RAM_BASE 16'h4000 // .o images land here
`define P_FILE_SKIP 16'd9 // .p images skip the system variables before 0x4009

`endif

// File: hw/zx_tape_pkg.sv
/* shared types of the tape fast-load path
   imported by the upload, loader and top modules */
package zx_tape_pkg;

	// ====================
	// loader FSM
	// ====================
	typedef enum logic [1:0] {
		LD_IDLE = 2'd0, // waiting for the entry fetch
		LD_READ = 2'd1, // buffer read issued
		LD_WRITE = 2'd2, // RAM write held until ready
		LD_DONE = 2'd3 // whole image copied
	} loader_state_e;

	// ====================
	// tape image format
	// ====================
	// .o is the ZX80 layout, loaded at the start of RAM
	// .p is the ZX81 layout, loaded after the system variables
	typedef enum logic {
		FMT_O = 1'b0,
		FMT_P = 1'b1
	} tape_format_e;

endpackage

// File: hw/tape_upload.sv
/* producer side of the tape path, turning download strobes into tape RAM writes
   and reporting when a complete image is available, how long it is and its format */
`timescale 1ns/1ns
`include "zx_tape_params.svh"

module tape_upload import zx_tape_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic download_i,
	input logic [7:0] index_i,
	input logic wr_i,
	input logic [`TAPE_ADDR_W-1:0] wr_addr_i,
	input logic [7:0] wr_data_i,
	output logic buf_we_o,
	output logic [`TAPE_ADDR_W-1:0] buf_waddr_o,
	output logic [7:0] buf_wdata_o,
	output logic tape_ready_o,
	output logic [`TAPE_ADDR_W-1:0] tape_last_o,
	output tape_format_e tape_fmt_o
);

	logic download_q;
	logic dl_rise;
	logic dl_fall;
	logic tape_wr; // write strobe that belongs to a tape image

	assign dl_rise = download_i & ~download_q;
	assign dl_fall = ~download_i & download_q;
	assign tape_wr = wr_i & (index_i != 8'd0); // index 0 is a ROM image

	// ====================
	// buffer write port
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buf_we_o <= 1'b0;
		end else begin
			buf_we_o <= tape_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		buf_waddr_o <= wr_addr_i;
		buf_wdata_o <= wr_data_i;
	end

	// ====================
	// download tracking
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			tape_ready_o <= 1'b0;
			tape_last_o <= '0;
			tape_fmt_o <= FMT_O;
		end else begin
			download_q <= download_i;

			// a new download invalidates whatever is in the buffer
			if (dl_rise) begin
				tape_ready_o <= 1'b0;
				tape_last_o <= '0;
			end else if (tape_wr && (wr_addr_i > tape_last_o)) begin
				tape_last_o <= wr_addr_i; // highest byte seen so far
			end

			if (dl_fall && (index_i != 8'd0)) begin
				tape_ready_o <= 1'b1;
				tape_fmt_o <= (index_i[7:6] == 2'd1) ? FMT_O : FMT_P;
			end
		end
	end

endmodule

// File: hw/tape_buffer.sv
/* tape RAM holding the downloaded image
   one write port from the upload side, one registered read port for the loader */
`timescale 1ns/1ns
`include "zx_tape_params.svh"

module tape_buffer #(
	parameter int ADDR_W = `TAPE_ADDR_W
) (
	input logic clk_sys,
	input logic we_i,
	input logic [ADDR_W-1:0] waddr_i,
	input logic [7:0] wdata_i,
	input logic [ADDR_W-1:0] raddr_i,
	output logic [7:0] rdata_o
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [7:0] mem [0:DEPTH-1];

	// ====================
	// write side
	// ====================
	always_ff @(posedge clk_sys) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// ====================
	// read side
	// ====================
	// data follows the address by exactly one clock
	always_ff @(posedge clk_sys) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

// File: hw/tape_loader.sv
/* consumer side of the tape path, started when the CPU fetches the ROM load entry
   and copying every buffered byte into system RAM over a ready-throttled write port */
`timescale 1ns/1ns
`include "zx_tape_params.svh"

module tape_loader import zx_tape_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic zx81_i,
	input logic fetch_i,
	input logic [15:0] fetch_addr_i,
	input logic tape_ready_i,
	input logic [`TAPE_ADDR_W-1:0] tape_last_i,
	input tape_format_e tape_fmt_i,
	output logic [`TAPE_ADDR_W-1:0] buf_raddr_o,
	input logic [7:0] buf_rdata_i,
	output logic [15:0] ram_addr_o,
	output logic [7:0] ram_data_o,
	output logic ram_we_o,
	input logic ram_ready_i,
	output logic loading_o,
	output logic done_o
);

	localparam int PAD_W = 16 - `TAPE_ADDR_W;

	loader_state_e state;
	loader_state_e state_nxt;

	logic [15:0] entry_addr;
	logic [15:0] limit_addr;
	logic [15:0] dest_base;
	logic start;
	logic abort;
	logic last_byte;
	logic wr_done; // RAM accepted the current byte

	logic [`TAPE_ADDR_W-1:0] rd_addr;
	logic [`TAPE_ADDR_W-1:0] last_q;
	tape_format_e fmt_q;

	// ====================
	// fetch decode
	// ====================
	always_comb begin
		if (zx81_i) begin
			entry_addr = `ZX81_LOAD_ENTRY;
			limit_addr = `ZX81_LOAD_END;
		end else begin
			entry_addr = `ZX80_LOAD_ENTRY;
			limit_addr = `ZX80_LOAD_END;
		end
	end

	assign start = fetch_i & tape_ready_i & (fetch_addr_i == entry_addr);
	// CPU left the patched loop so the copy is given up
	assign abort = fetch_i & ((fetch_addr_i < entry_addr) | (fetch_addr_i >= limit_addr));

	assign wr_done = (state == LD_WRITE) & ram_ready_i;
	assign last_byte = (rd_addr == last_q);

	// ====================
	// FSM
	// ====================
	always_comb begin
		state_nxt = state;
		if (start) begin
			state_nxt = LD_READ; // entry fetch always (re)starts from byte 0
		end else begin
			case (state)
				LD_IDLE: state_nxt = LD_IDLE;
				LD_READ: begin
					if (abort) begin
						state_nxt = LD_IDLE;
					end else begin
						state_nxt = LD_WRITE; // read data valid next cycle
					end
				end
				LD_WRITE: begin
					if (abort) begin
						state_nxt = LD_IDLE;
					end else if (ram_ready_i) begin
						state_nxt = last_byte ? LD_DONE : LD_READ;
					end
				end
				LD_DONE: state_nxt = LD_DONE; // held until next start
				default: state_nxt = LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= LD_IDLE;
			rd_addr <= '0;
		end else begin
			state <= state_nxt;
			if (start) begin
				rd_addr <= '0;
			end else if (wr_done && !last_byte) begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	// image length and format are frozen for the whole copy
	always_ff @(posedge clk_sys) begin
		if (start) begin
			last_q <= tape_last_i;
			fmt_q <= tape_fmt_i;
		end
	end

	// ====================
	// buffer and RAM ports
	// ====================
	assign buf_raddr_o = rd_addr; // stays put while LD_WRITE waits

	always_comb begin
		if (fmt_q == FMT_P) begin
			dest_base = `RAM_BASE + `P_FILE_SKIP; // skip system variables
		end else begin
			dest_base = `RAM_BASE;
		end
	end

	assign ram_addr_o = dest_base + {{PAD_W{1'b0}}, rd_addr};
	assign ram_data_o = buf_rdata_i;
	assign ram_we_o = (state == LD_WRITE);

	assign loading_o = (state == LD_READ) | (state == LD_WRITE);
	assign done_o = (state == LD_DONE);

endmodule

// File: hw/zx_tape_top.sv
/* top level of the tape fast-load path
   connects the download producer, the tape RAM and the RAM loader */
`timescale 1ns/1ns
`include "zx_tape_params.svh"

module zx_tape_top import zx_tape_pkg::*; (
	input logic clk_sys,
	input logic reset,
	// download port
	input logic download_i,
	input logic [7:0] index_i,
	input logic wr_i,
	input logic [`TAPE_ADDR_W-1:0] wr_addr_i,
	input logic [7:0] wr_data_i,
	// CPU fetch
	input logic zx81_i,
	input logic fetch_i,
	input logic [15:0] fetch_addr_i,
	// system RAM write port
	output logic [15:0] ram_addr_o,
	output logic [7:0] ram_data_o,
	output logic ram_we_o,
	input logic ram_ready_i,
	// status
	output logic loading_o,
	output logic done_o,
	output logic tape_ready_o
);

	logic buf_we;
	logic [`TAPE_ADDR_W-1:0] buf_waddr;
	logic [7:0] buf_wdata;
	logic [`TAPE_ADDR_W-1:0] buf_raddr;
	logic [7:0] buf_rdata;
	logic [`TAPE_ADDR_W-1:0] tape_last;
	tape_format_e tape_fmt;

	// ====================
	// producer
	// ====================
	tape_upload u_tape_upload (
		.clk_sys(clk_sys),
		.reset(reset),
		.download_i(download_i),
		.index_i(index_i),
		.wr_i(wr_i),
		.wr_addr_i(wr_addr_i),
		.wr_data_i(wr_data_i),
		.buf_we_o(buf_we),
		.buf_waddr_o(buf_waddr),
		.buf_wdata_o(buf_wdata),
		.tape_ready_o(tape_ready_o), // also feeds the loader trigger
		.tape_last_o(tape_last),
		.tape_fmt_o(tape_fmt)
	);

	tape_buffer #(
		.ADDR_W(`TAPE_ADDR_W)
	) u_tape_buffer (
		.clk_sys(clk_sys),
		.we_i(buf_we),
		.waddr_i(buf_waddr),
		.wdata_i(buf_wdata),
		.raddr_i(buf_raddr),
		.rdata_o(buf_rdata)
	);

	// ====================
	// consumer
	// ====================
	tape_loader u_tape_loader (
		.clk_sys(clk_sys),
		.reset(reset),
		.zx81_i(zx81_i),
		.fetch_i(fetch_i),
		.fetch_addr_i(fetch_addr_i),
		.tape_ready_i(tape_ready_o),
		.tape_last_i(tape_last),
		.tape_fmt_i(tape_fmt),
		.buf_raddr_o(buf_raddr),
		.buf_rdata_i(buf_rdata),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.ram_we_o(ram_we_o),
		.ram_ready_i(ram_ready_i),
		.loading_o(loading_o),
		.done_o(done_o)
	);

endmodule

// File: test/tape_checker.sv
/* scoreboard for the tape fast-load path, taking the expected image from the testbench
   and checking every accepted RAM write and the loader status against it */
`timescale 1ns/1ns
`include "zx_tape_params.svh"

module tape_checker (
	input logic clk_sys,
	input logic ram_we_i,
	input logic ram_ready_i,
	input logic [15:0] ram_addr_i,
	input logic [7:0] ram_data_i,
	input logic loading_i,
	input logic done_i,
	input logic case_start_i,
	input logic exp_fmt_p_i,
	input logic [15:0] exp_len_i,
	input logic allow_i,
	input logic exp_we_i,
	input logic [`TAPE_ADDR_W-1:0] exp_idx_i,
	input logic [7:0] exp_byte_i,
	output int wr_count_o,
	output int err_count_o
);

	logic [7:0] exp_data [0:(1 << `TAPE_ADDR_W)-1];
	logic [15:0] exp_pos = 16'd0; // next byte the loader should write
	logic [15:0] exp_base;
	logic done_q = 1'b0;
	logic pend_q = 1'b0; // write offered but not yet accepted
	logic [15:0] pend_addr = 16'd0;
	logic [7:0] pend_data = 8'd0;
	int wr_count = 0;
	int err_count = 0;

	assign wr_count_o = wr_count;
	assign err_count_o = err_count;

	// .p images skip the system variables
	assign exp_base = exp_fmt_p_i ? (`RAM_BASE + `P_FILE_SKIP) : `RAM_BASE;

	task automatic report(input string msg);
		$display("Error: %0t ns: %s", $time, msg);
		err_count++;
	endtask

	// ====================
	// write monitor
	// ====================
	always @(posedge clk_sys) begin
		if (exp_we_i) begin
			exp_data[exp_idx_i] = exp_byte_i;
		end
		if (case_start_i) begin
			exp_pos = 16'd0;
		end
		// a stalled write must be held unchanged unless the copy was dropped
		if (pend_q && loading_i) begin
			if (!ram_we_i || ram_addr_i !== pend_addr || ram_data_i !== pend_data) begin
				report("RAM write changed or dropped while ram_ready_i was low");
			end
		end
		if (ram_we_i && ram_ready_i) begin // one accepted transfer
			wr_count++;
			if (!allow_i) begin
				report($sformatf("RAM write to 0x%h with no valid load running", ram_addr_i));
			end else if (exp_pos >= exp_len_i) begin
				report($sformatf("extra RAM write to 0x%h past the image end", ram_addr_i));
			end else begin
				if (ram_addr_i !== exp_base + exp_pos) begin
					report($sformatf("RAM address 0x%h, expected 0x%h", ram_addr_i,
						exp_base + exp_pos));
				end
				if (ram_data_i !== exp_data[exp_pos[`TAPE_ADDR_W-1:0]]) begin
					report($sformatf("RAM data 0x%h at byte %0d, expected 0x%h", ram_data_i,
						exp_pos, exp_data[exp_pos[`TAPE_ADDR_W-1:0]]));
				end
				exp_pos = exp_pos + 16'd1;
			end
			if (!loading_i) begin
				report("ram_we_o high while loading_o is low");
			end
		end
		if (done_i && !done_q && allow_i && (exp_pos != exp_len_i)) begin
			report($sformatf("done_o rose after %0d of %0d bytes", exp_pos, exp_len_i));
		end
		if (done_i && loading_i) begin
			report("done_o and loading_o high together");
		end
		done_q = done_i;
		pend_q = ram_we_i && !ram_ready_i;
		pend_addr = ram_addr_i;
		pend_data = ram_data_i;
	end

endmodule

// File: test/tb_zx_tape.sv
/* testbench for the tape fast-load path, replaying the cases file through download,
   entry fetch and a stalling RAM port while tape_checker compares the writes */
`timescale 1ns/1ns
`include "zx_tape_params.svh"

module tb_zx_tape;

	localparam int FIELDS = 7;
	localparam int MAX_CASES = 16;

	logic clk_sys = 1'b0;
	logic reset = 1'b1;
	logic download = 1'b0;
	logic [7:0] index = 8'd0;
	logic wr = 1'b0;
	logic [`TAPE_ADDR_W-1:0] wr_addr = '0;
	logic [7:0] wr_data = 8'd0;
	logic zx81 = 1'b0;
	logic fetch = 1'b0;
	logic [15:0] fetch_addr = 16'd0;
	logic ram_ready = 1'b1;
	logic [15:0] ram_addr;
	logic [7:0] ram_data;
	logic ram_we;
	logic loading;
	logic done;
	logic tape_ready;

	// expected image, handed to the checker
	logic case_start = 1'b0;
	logic exp_fmt_p = 1'b0;
	logic [15:0] exp_len = 16'd0;
	logic allow = 1'b0;
	logic exp_we = 1'b0;
	logic [`TAPE_ADDR_W-1:0] exp_idx = '0;
	logic [7:0] exp_byte = 8'd0;
	int wr_count;
	int err_count;

	logic [15:0] case_mem [0:FIELDS*MAX_CASES-1];
	int seed = 79;
	int stall_seed = 79;
	int stall_pct = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int tb_errors = 0;
	int n_pass = 0;
	int n_fail = 0;

	zx_tape_top u_zx_tape_top (
		.clk_sys(clk_sys), .reset(reset),
		.download_i(download), .index_i(index), .wr_i(wr),
		.wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.zx81_i(zx81), .fetch_i(fetch), .fetch_addr_i(fetch_addr),
		.ram_addr_o(ram_addr), .ram_data_o(ram_data), .ram_we_o(ram_we),
		.ram_ready_i(ram_ready),
		.loading_o(loading), .done_o(done), .tape_ready_o(tape_ready)
	);

	tape_checker u_tape_checker (
		.clk_sys(clk_sys), .ram_we_i(ram_we), .ram_ready_i(ram_ready),
		.ram_addr_i(ram_addr), .ram_data_i(ram_data), .loading_i(loading), .done_i(done),
		.case_start_i(case_start), .exp_fmt_p_i(exp_fmt_p), .exp_len_i(exp_len),
		.allow_i(allow), .exp_we_i(exp_we), .exp_idx_i(exp_idx), .exp_byte_i(exp_byte),
		.wr_count_o(wr_count), .err_count_o(err_count)
	);

	// ====================
	// clock, RAM stalls, watchdog
	// ====================
	always #4 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		int rnd;
		rnd = $random(stall_seed);
		ram_ready = ((rnd & 32'h7FFF_FFFF) % 100) >= stall_pct;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic expect_true(input logic ok, input string msg);
		if (!ok) begin
			$display("Error: %0t ns: %s", $time, msg);
			tb_errors++;
		end
	endtask

	task automatic pulse_fetch(input logic [15:0] addr);
		@(negedge clk_sys);
		fetch = 1'b1;
		fetch_addr = addr;
		@(negedge clk_sys);
		fetch = 1'b0;
	endtask

	// one write strobe per byte and mirrored to the checker
	task automatic download_image(input logic [7:0] idx, input int len);
		int k;
		int r;
		@(negedge clk_sys);
		download = 1'b1;
		index = idx;
		for (k = 0; k < len; k++) begin
			@(negedge clk_sys);
			r = $random(seed);
			wr = 1'b1;
			wr_addr = k[`TAPE_ADDR_W-1:0];
			wr_data = r[7:0];
			exp_we = 1'b1;
			exp_idx = k[`TAPE_ADDR_W-1:0];
			exp_byte = r[7:0];
		end
		@(negedge clk_sys);
		wr = 1'b0;
		exp_we = 1'b0;
		download = 1'b0; // format is taken at this edge with index held
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic report_case(input int id, input int errs_before);
		int errs;
		errs = tb_errors + err_count - errs_before;
		if (errs == 0) begin
			$display("case %0d: PASS", id);
			n_pass++;
		end else begin
			$display("Error: %0t ns: case %0d failed with %0d errors", $time, id, errs);
			n_fail++;
		end
	endtask

	task automatic run_case(input int id, input int model, input int idx, input int len,
		input int cseed, input int stall, input int abort_addr);
		int errs_before;
		int wr_before;
		int snap;
		logic [15:0] entry;
		logic [15:0] other_entry;
		errs_before = tb_errors + err_count;
		stall_pct = stall;
		if (cseed != 0) begin
			seed = cseed; // restart the data stream
		end
		entry = (model != 0) ? `ZX81_LOAD_ENTRY : `ZX80_LOAD_ENTRY;
		other_entry = (model != 0) ? `ZX80_LOAD_ENTRY : `ZX81_LOAD_ENTRY;
		@(negedge clk_sys);
		zx81 = model[0];
		allow = 1'b0;
		exp_fmt_p = (idx[7:6] != 2'b01); // 0x40..0x7F are .o images
		exp_len = len[15:0];
		case_start = 1'b1;
		@(negedge clk_sys);
		case_start = 1'b0;
		download_image(idx[7:0], len);
		expect_true(tape_ready == (idx != 0), "tape_ready_o wrong after the download");

		// wrong model's entry must not trigger
		wr_before = wr_count;
		pulse_fetch(other_entry);
		repeat (8) @(negedge clk_sys);
		expect_true(wr_count == wr_before && !loading,
			"other model's entry fetch started a copy");

		allow = (idx != 0);
		pulse_fetch(entry);
		if (idx == 0) begin
			repeat (16) @(negedge clk_sys);
			expect_true(wr_count == wr_before && !loading,
				"entry fetch after a ROM download copied");
		end else if (abort_addr != 0) begin
			expect_true(loading, "loading_o did not rise after the entry fetch");
			while (wr_count - wr_before < len / 2) @(negedge clk_sys);
			pulse_fetch(abort_addr[15:0]);
			snap = wr_count;
			expect_true(!loading && !ram_we, "loading_o or ram_we_o still high after the abort");
			repeat (20) @(negedge clk_sys);
			expect_true(wr_count == snap && !done, "writes went on or done_o rose after the abort");
		end else begin
			expect_true(loading, "loading_o did not rise after the entry fetch");
			while (!done) @(negedge clk_sys);
			expect_true(wr_count - wr_before == len, "RAM write count differs from image length");
			expect_true(!loading, "loading_o still high with done_o set");
		end
		allow = 1'b0;
		report_case(id, errs_before);
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int base;
		int k;
		int errs_before;
		for (k = 0; k < FIELDS * MAX_CASES; k++) begin
			case_mem[k] = 16'hFFFF; // end of the case list
		end
		$readmemh("test/tape_cases.txt", case_mem);
		cycle_limit = 2000;
		for (base = 0; base < FIELDS * MAX_CASES && case_mem[base] != 16'hFFFF;
			base += FIELDS) begin
			cycle_limit += 4 * int'(case_mem[base + 3]) * (1 + int'(case_mem[base + 5]));
		end
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;

		// nothing downloaded yet so neither entry may start a copy
		errs_before = tb_errors + err_count;
		expect_true(!tape_ready, "tape_ready_o high after reset");
		zx81 = 1'b1;
		pulse_fetch(`ZX81_LOAD_ENTRY);
		zx81 = 1'b0;
		pulse_fetch(`ZX80_LOAD_ENTRY);
		repeat (8) @(negedge clk_sys);
		expect_true(wr_count == 0 && !loading && !done, "entry fetch copied with no tape loaded");
		report_case(0, errs_before);

		for (base = 0; base < FIELDS * MAX_CASES && case_mem[base] != 16'hFFFF;
			base += FIELDS) begin
			run_case(int'(case_mem[base]), int'(case_mem[base + 1]), int'(case_mem[base + 2]),
				int'(case_mem[base + 3]), int'(case_mem[base + 4]), int'(case_mem[base + 5]),
				int'(case_mem[base + 6]));
		end

		$display("%0d cases passed, %0d failed, %0d checker errors", n_pass, n_fail, err_count);
		if (n_fail == 0 && tb_errors == 0 && err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: test/tape_cases.txt
// id model index length seed stall abort, all hex, model 1 is ZX81
// seed 0 continues the data stream, stall is the percent of ready-low cycles, abort 0 means none
0001 0001 0080 0040 004F 0000 0000
0002 0000 0040 0030 0000 0000 0000
0003 0001 0080 0040 004F 0028 0000
0004 0000 0041 0050 0000 0032 0000
0005 0001 00C0 0060 0000 0000 0100
0006 0000 0040 0040 0000 0014 0300
0007 0001 0000 0020 0000 0000 0000
0008 0001 0001 0100 0000 000A 0000
0009 0000 007F 0001 0000 0000 0000
000A 0001 0080 0010 0000 005A 0000

// File: src.f
+incdir+hw
hw/zx_tape_pkg.sv
hw/tape_upload.sv
hw/tape_buffer.sv
hw/tape_loader.sv
hw/zx_tape_top.sv
test/tape_checker.sv
test/tb_zx_tape.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the tape fast-load testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -j 0 \
	-f src.f --top-module tb_zx_tape -Mdir obj_dir

./obj_dir/Vtb_zx_tape | tee sim.log

if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
